/* design/rv_pkg.sv */
package rv_pkg;

	localparam int xlen = 32;
	localparam int reg_count = 16;
	localparam int reg_addr_w = 4;  // rv32e, x0..x15

	localparam logic [6:0] op_lui    = 7'b0110111;
	localparam logic [6:0] op_auipc  = 7'b0010111;
	localparam logic [6:0] op_jal    = 7'b1101111;
	localparam logic [6:0] op_jalr   = 7'b1100111;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_load   = 7'b0000011;
	localparam logic [6:0] op_store  = 7'b0100011;
	localparam logic [6:0] op_op_imm = 7'b0010011;
	localparam logic [6:0] op_op     = 7'b0110011;
	localparam logic [6:0] op_system = 7'b1110011;

	localparam logic [31:0] ebreak_word = 32'h0010_0073;

	// funct3 of op and op_imm
	localparam logic [2:0] f3_add_sub = 3'b000;
	localparam logic [2:0] f3_sll     = 3'b001;
	localparam logic [2:0] f3_slt     = 3'b010;
	localparam logic [2:0] f3_sltu    = 3'b011;
	localparam logic [2:0] f3_xor     = 3'b100;
	localparam logic [2:0] f3_srl_sra = 3'b101;
	localparam logic [2:0] f3_or      = 3'b110;
	localparam logic [2:0] f3_and     = 3'b111;

	// funct3 of branches
	localparam logic [2:0] f3_beq  = 3'b000;
	localparam logic [2:0] f3_bne  = 3'b001;
	localparam logic [2:0] f3_blt  = 3'b100;
	localparam logic [2:0] f3_bge  = 3'b101;
	localparam logic [2:0] f3_bltu = 3'b110;
	localparam logic [2:0] f3_bgeu = 3'b111;

	localparam logic [3:0] alu_add  = 4'd0;
	localparam logic [3:0] alu_sub  = 4'd1;
	localparam logic [3:0] alu_slt  = 4'd2;
	localparam logic [3:0] alu_sltu = 4'd3;
	localparam logic [3:0] alu_and  = 4'd4;
	localparam logic [3:0] alu_or   = 4'd5;
	localparam logic [3:0] alu_xor  = 4'd6;
	localparam logic [3:0] alu_sll  = 4'd7;
	localparam logic [3:0] alu_srl  = 4'd8;
	localparam logic [3:0] alu_sra  = 4'd9;

	localparam logic [1:0] mem_byte = 2'b00;  // same as funct3[1:0]
	localparam logic [1:0] mem_half = 2'b01;
	localparam logic [1:0] mem_word = 2'b10;

	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r;  // r, i and u layouts
		struct packed {
			logic [6:0] imm_hi;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] imm_lo;
			logic [6:0] opcode;
		} s;  // s and b layouts
	} inst_u;

endpackage

/* design/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
	input  logic                          clk,
	input  logic                          reset,
	input  logic [rv_pkg::reg_addr_w-1:0] i_rs1,
	input  logic [rv_pkg::reg_addr_w-1:0] i_rs2,
	input  logic [rv_pkg::reg_addr_w-1:0] i_rd,
	input  logic                          i_wen,
	input  logic [rv_pkg::xlen-1:0]       i_wdata,
	output logic [rv_pkg::xlen-1:0]       o_rs1_data,
	output logic [rv_pkg::xlen-1:0]       o_rs2_data
);
	import rv_pkg::*;

	logic [xlen-1:0] regs [reg_count];

	assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];  // x0 reads zero
	assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < reg_count; i++) begin
				regs[i] <= '0;
			end
		end else if (i_wen) begin
			regs[i_rd] <= i_wdata;
		end
	end

	// decode and control together keep x0 writes away
	assert property (@(posedge clk) disable iff (reset) i_wen |-> (i_rd != '0));

endmodule

/* design/inst_decode.sv */
`timescale 1ns/1ps

module inst_decode (
	input  rv_pkg::inst_u                 i_inst,
	output logic [rv_pkg::reg_addr_w-1:0] o_rs1,
	output logic [rv_pkg::reg_addr_w-1:0] o_rs2,
	output logic [rv_pkg::reg_addr_w-1:0] o_rd,
	output logic [rv_pkg::xlen-1:0]       o_imm,
	output logic [3:0]                    o_alu_op,
	output logic                          o_src_a_pc,
	output logic                          o_src_a_zero,
	output logic                          o_src_b_imm,
	output logic [2:0]                    o_br_funct3,
	output logic                          o_is_branch,
	output logic                          o_is_jal,
	output logic                          o_is_jalr,
	output logic                          o_is_mem,
	output logic                          o_is_store,
	output logic [1:0]                    o_mem_size,
	output logic                          o_load_unsigned,
	output logic                          o_is_ebreak,
	output logic                          o_reg_wen
);
	import rv_pkg::*;

	logic [6:0]      opcode;
	logic [2:0]      funct3;
	logic [6:0]      funct7;
	logic            is_lui, is_auipc, is_load, is_op_imm, is_op;
	logic [xlen-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

	assign opcode = i_inst.r.opcode;
	assign funct3 = i_inst.r.funct3;
	assign funct7 = i_inst.r.funct7;

	assign is_lui    = (opcode == op_lui);
	assign is_auipc  = (opcode == op_auipc);
	assign is_load   = (opcode == op_load);
	assign is_op_imm = (opcode == op_op_imm);
	assign is_op     = (opcode == op_op);

	assign o_is_jal    = (opcode == op_jal);
	assign o_is_jalr   = (opcode == op_jalr);
	assign o_is_branch = (opcode == op_branch);
	assign o_is_store  = (opcode == op_store);
	assign o_is_mem    = is_load || o_is_store;
	assign o_is_ebreak = (opcode == op_system) && (i_inst == ebreak_word);

	// rv32e only decodes the low four register bits
	assign o_rs1 = i_inst.r.rs1[reg_addr_w-1:0];
	assign o_rs2 = i_inst.r.rs2[reg_addr_w-1:0];
	assign o_rd  = i_inst.r.rd[reg_addr_w-1:0];

	assign imm_i = {{20{funct7[6]}}, funct7, i_inst.r.rs2};
	assign imm_s = {{20{i_inst.s.imm_hi[6]}}, i_inst.s.imm_hi, i_inst.s.imm_lo};
	assign imm_b = {{19{i_inst.s.imm_hi[6]}}, i_inst.s.imm_hi[6], i_inst.s.imm_lo[0],
		i_inst.s.imm_hi[5:0], i_inst.s.imm_lo[4:1], 1'b0};
	assign imm_u = {funct7, i_inst.r.rs2, i_inst.r.rs1, funct3, 12'h000};
	assign imm_j = {{12{funct7[6]}}, i_inst.r.rs1, funct3, i_inst.r.rs2[0],
		funct7[5:0], i_inst.r.rs2[4:1], 1'b0};

	always_comb begin
		if (o_is_store) begin
			o_imm = imm_s;
		end else if (o_is_branch) begin
			o_imm = imm_b;
		end else if (o_is_jal) begin
			o_imm = imm_j;
		end else if (is_lui || is_auipc) begin
			o_imm = imm_u;
		end else begin
			o_imm = imm_i;
		end
	end

	always_comb begin
		o_alu_op = alu_add;  // address and upper-imm adds
		if (is_op || is_op_imm) begin
			case (funct3)
				f3_add_sub: o_alu_op = (is_op && funct7[5]) ? alu_sub : alu_add;
				f3_sll:     o_alu_op = alu_sll;
				f3_slt:     o_alu_op = alu_slt;
				f3_sltu:    o_alu_op = alu_sltu;
				f3_xor:     o_alu_op = alu_xor;
				f3_srl_sra: o_alu_op = funct7[5] ? alu_sra : alu_srl;
				f3_or:      o_alu_op = alu_or;
				f3_and:     o_alu_op = alu_and;
			endcase
		end
	end

	always_comb begin
		case (funct3[1:0])
			2'b00:   o_mem_size = mem_byte;
			2'b01:   o_mem_size = mem_half;
			default: o_mem_size = mem_word;
		endcase
	end

	assign o_load_unsigned = funct3[2];
	assign o_br_funct3 = funct3;
	assign o_src_a_pc = is_auipc;
	assign o_src_a_zero = is_lui;
	assign o_src_b_imm = !(is_op || o_is_branch);

	assign o_reg_wen = (is_lui || is_auipc || o_is_jal || o_is_jalr || is_load
		|| is_op_imm || is_op) && (o_rd != '0);

endmodule

/* design/alu_branch.sv */
`timescale 1ns/1ps

module alu_branch (
	input  logic [rv_pkg::xlen-1:0] i_pc,
	input  logic [rv_pkg::xlen-1:0] i_rs1_data,
	input  logic [rv_pkg::xlen-1:0] i_rs2_data,
	input  logic [rv_pkg::xlen-1:0] i_imm,
	input  logic [3:0]              i_alu_op,
	input  logic                    i_src_a_pc,
	input  logic                    i_src_a_zero,
	input  logic                    i_src_b_imm,
	input  logic [2:0]              i_br_funct3,
	output logic [rv_pkg::xlen-1:0] o_alu_result,
	output logic                    o_br_taken
);
	import rv_pkg::*;

	logic [xlen-1:0] op_a;
	logic [xlen-1:0] op_b;
	logic [4:0]      shamt;

	assign op_a = i_src_a_pc ? i_pc : (i_src_a_zero ? '0 : i_rs1_data);  // auipc / lui
	assign op_b = i_src_b_imm ? i_imm : i_rs2_data;
	assign shamt = op_b[4:0];

	always_comb begin
		case (i_alu_op)
			alu_add:  o_alu_result = op_a + op_b;
			alu_sub:  o_alu_result = op_a - op_b;
			alu_slt:  o_alu_result = {31'd0, $signed(op_a) < $signed(op_b)};
			alu_sltu: o_alu_result = {31'd0, op_a < op_b};
			alu_and:  o_alu_result = op_a & op_b;
			alu_or:   o_alu_result = op_a | op_b;
			alu_xor:  o_alu_result = op_a ^ op_b;
			alu_sll:  o_alu_result = op_a << shamt;
			alu_srl:  o_alu_result = op_a >> shamt;
			alu_sra:  o_alu_result = $unsigned($signed(op_a) >>> shamt);
			default:  o_alu_result = '0;
		endcase
	end

	// compares always use the register pair
	always_comb begin
		case (i_br_funct3)
			f3_beq:  o_br_taken = (i_rs1_data == i_rs2_data);
			f3_bne:  o_br_taken = (i_rs1_data != i_rs2_data);
			f3_blt:  o_br_taken = ($signed(i_rs1_data) < $signed(i_rs2_data));
			f3_bge:  o_br_taken = ($signed(i_rs1_data) >= $signed(i_rs2_data));
			f3_bltu: o_br_taken = (i_rs1_data < i_rs2_data);
			f3_bgeu: o_br_taken = (i_rs1_data >= i_rs2_data);
			default: o_br_taken = 1'b0;
		endcase
	end

endmodule

/* design/lsu_align.sv */
`timescale 1ns/1ps

module lsu_align (
	input  logic [rv_pkg::xlen-1:0] i_addr,
	input  logic [rv_pkg::xlen-1:0] i_store_data,
	input  logic [1:0]              i_mem_size,
	input  logic                    i_is_store,
	input  logic                    i_load_unsigned,
	input  logic [rv_pkg::xlen-1:0] i_lsu_rdata,
	output logic [rv_pkg::xlen-1:0] o_lsu_addr,
	output logic [1:0]              o_lsu_size,
	output logic                    o_lsu_wen,
	output logic [rv_pkg::xlen-1:0] o_lsu_wdata,
	output logic [3:0]              o_lsu_wmask,
	output logic [rv_pkg::xlen-1:0] o_load_data
);
	import rv_pkg::*;

	logic [1:0]      offset;
	logic [3:0]      lane_mask;
	logic [xlen-1:0] rdata_shifted;
	logic [7:0]      load_byte;
	logic [15:0]     load_half;

	assign offset = i_addr[1:0];
	assign o_lsu_addr = i_addr;
	assign o_lsu_size = i_mem_size;
	assign o_lsu_wen = i_is_store;
	assign o_lsu_wdata = i_store_data << {offset, 3'b000};  // into byte lanes

	always_comb begin
		case (i_mem_size)
			mem_byte: lane_mask = 4'b0001 << offset;
			mem_half: lane_mask = i_addr[1] ? 4'b1100 : 4'b0011;
			default:  lane_mask = 4'b1111;
		endcase
	end

	assign o_lsu_wmask = i_is_store ? lane_mask : 4'b0000;

	assign rdata_shifted = i_lsu_rdata >> {offset, 3'b000};
	assign load_byte = rdata_shifted[7:0];
	assign load_half = rdata_shifted[15:0];

	always_comb begin
		case (i_mem_size)
			mem_byte: o_load_data = {{24{load_byte[7] & ~i_load_unsigned}}, load_byte};
			mem_half: o_load_data = {{16{load_half[15] & ~i_load_unsigned}}, load_half};
			default:  o_load_data = i_lsu_rdata;
		endcase
	end

	// a write always carries at least one lane, a read none
	always_comb begin
		assert (o_lsu_wen == (o_lsu_wmask != 4'b0000));
	end

endmodule

/* design/core_ctrl.sv */
`timescale 1ns/1ps

module core_ctrl #(
	parameter logic [rv_pkg::xlen-1:0] reset_pc = 32'h3000_0000
) (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    i_ifu_resp_valid,
	input  logic [rv_pkg::xlen-1:0] i_ifu_rdata,
	input  logic                    i_is_mem,
	input  logic                    i_is_branch,
	input  logic                    i_is_jal,
	input  logic                    i_is_jalr,
	input  logic                    i_is_ebreak,
	input  logic                    i_reg_wen,
	input  logic [rv_pkg::xlen-1:0] i_imm,
	input  logic [rv_pkg::xlen-1:0] i_alu_result,
	input  logic                    i_br_taken,
	input  logic                    i_lsu_resp_valid,
	input  logic [rv_pkg::xlen-1:0] i_load_data,
	output logic                    o_ifu_req_valid,
	output logic [rv_pkg::xlen-1:0] o_ifu_addr,
	output logic                    o_lsu_req_valid,
	output rv_pkg::inst_u           o_inst,
	output logic [rv_pkg::xlen-1:0] o_pc,
	output logic                    o_rd_wen,
	output logic [rv_pkg::xlen-1:0] o_rd_wdata,
	output logic                    o_halt
);
	import rv_pkg::*;

	localparam logic [2:0] s_fetch  = 3'd0;
	localparam logic [2:0] s_wait_i = 3'd1;
	localparam logic [2:0] s_exec   = 3'd2;
	localparam logic [2:0] s_mem    = 3'd3;
	localparam logic [2:0] s_wait_d = 3'd4;
	localparam logic [2:0] s_wb     = 3'd5;
	localparam logic [2:0] s_halt   = 3'd6;

	logic [2:0]      state;
	logic [xlen-1:0] pc;
	logic [xlen-1:0] pc_plus4;
	logic [xlen-1:0] next_pc;
	logic [xlen-1:0] alu_q;
	logic [xlen-1:0] load_q;

	assign pc_plus4 = pc + 32'd4;
	assign o_pc = pc;
	assign o_ifu_addr = pc;
	assign o_ifu_req_valid = (state == s_fetch) && !reset;  // no fetch while held in reset
	assign o_lsu_req_valid = (state == s_mem);
	assign o_rd_wen = (state == s_wb) && i_reg_wen;
	assign o_halt = (state == s_halt);

	always_comb begin
		if (i_is_jal || (i_is_branch && i_br_taken)) begin
			next_pc = pc + i_imm;
		end else if (i_is_jalr) begin
			next_pc = {alu_q[xlen-1:1], 1'b0};
		end else begin
			next_pc = pc_plus4;
		end
	end

	always_comb begin
		if (i_is_jal || i_is_jalr) begin
			o_rd_wdata = pc_plus4;  // link
		end else if (i_is_mem) begin
			o_rd_wdata = load_q;  // stores never reach here with wen
		end else begin
			o_rd_wdata = alu_q;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= s_fetch;
			pc <= reset_pc;
			o_inst <= '0;
		end else begin
			case (state)
				s_fetch: state <= s_wait_i;
				s_wait_i: begin
					if (i_ifu_resp_valid) begin
						o_inst <= i_ifu_rdata;
						state <= s_exec;
					end
				end
				s_exec: begin
					if (i_is_ebreak) begin
						state <= s_halt;
					end else if (i_is_mem) begin
						state <= s_mem;
					end else begin
						state <= s_wb;
					end
				end
				s_mem: state <= s_wait_d;
				s_wait_d: begin
					if (i_lsu_resp_valid) begin
						state <= s_wb;
					end
				end
				s_wb: begin
					pc <= next_pc;
					state <= s_fetch;
				end
				default: state <= s_halt;  // sticky until reset
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == s_exec) begin
			alu_q <= i_alu_result;
		end
		if (state == s_wait_d && i_lsu_resp_valid) begin
			load_q <= i_load_data;
		end
	end

	assert property (@(posedge clk) disable iff (reset)
		!(o_ifu_req_valid && o_lsu_req_valid));

endmodule

/* design/rv_core.sv */
`timescale 1ns/1ps

module rv_core #(
	parameter logic [rv_pkg::xlen-1:0] reset_pc = 32'h3000_0000
) (
	input  logic                    clk,
	input  logic                    reset,
	output logic                    o_ifu_req_valid,
	output logic [rv_pkg::xlen-1:0] o_ifu_addr,
	input  logic                    i_ifu_resp_valid,
	input  logic [rv_pkg::xlen-1:0] i_ifu_rdata,
	output logic                    o_lsu_req_valid,
	output logic [rv_pkg::xlen-1:0] o_lsu_addr,
	output logic [1:0]              o_lsu_size,
	output logic                    o_lsu_wen,
	output logic [rv_pkg::xlen-1:0] o_lsu_wdata,
	output logic [3:0]              o_lsu_wmask,
	input  logic                    i_lsu_resp_valid,
	input  logic [rv_pkg::xlen-1:0] i_lsu_rdata,
	output logic                    o_halt
);
	import rv_pkg::*;

	inst_u                 inst;
	logic [xlen-1:0]       pc;
	logic [reg_addr_w-1:0] rs1;
	logic [reg_addr_w-1:0] rs2;
	logic [reg_addr_w-1:0] rd;
	logic [xlen-1:0]       imm;
	logic [3:0]            alu_op;
	logic                  src_a_pc;
	logic                  src_a_zero;
	logic                  src_b_imm;
	logic [2:0]            br_funct3;
	logic                  is_branch;
	logic                  is_jal;
	logic                  is_jalr;
	logic                  is_mem;
	logic                  is_store;
	logic [1:0]            mem_size;
	logic                  load_unsigned;
	logic                  is_ebreak;
	logic                  reg_wen;
	logic [xlen-1:0]       rs1_data;
	logic [xlen-1:0]       rs2_data;
	logic [xlen-1:0]       alu_result;
	logic                  br_taken;
	logic [xlen-1:0]       load_data;
	logic                  rd_wen;
	logic [xlen-1:0]       rd_wdata;

	core_ctrl #(.reset_pc(reset_pc)) u_core_ctrl (
		.clk(clk), .reset(reset),
		.i_ifu_resp_valid(i_ifu_resp_valid), .i_ifu_rdata(i_ifu_rdata),
		.i_is_mem(is_mem), .i_is_branch(is_branch), .i_is_jal(is_jal),
		.i_is_jalr(is_jalr), .i_is_ebreak(is_ebreak), .i_reg_wen(reg_wen),
		.i_imm(imm), .i_alu_result(alu_result), .i_br_taken(br_taken),
		.i_lsu_resp_valid(i_lsu_resp_valid), .i_load_data(load_data),
		.o_ifu_req_valid(o_ifu_req_valid), .o_ifu_addr(o_ifu_addr),
		.o_lsu_req_valid(o_lsu_req_valid), .o_inst(inst), .o_pc(pc),
		.o_rd_wen(rd_wen), .o_rd_wdata(rd_wdata), .o_halt(o_halt)
	);

	inst_decode u_inst_decode (
		.i_inst(inst), .o_rs1(rs1), .o_rs2(rs2), .o_rd(rd), .o_imm(imm),
		.o_alu_op(alu_op), .o_src_a_pc(src_a_pc), .o_src_a_zero(src_a_zero),
		.o_src_b_imm(src_b_imm), .o_br_funct3(br_funct3), .o_is_branch(is_branch),
		.o_is_jal(is_jal), .o_is_jalr(is_jalr), .o_is_mem(is_mem),
		.o_is_store(is_store), .o_mem_size(mem_size),
		.o_load_unsigned(load_unsigned), .o_is_ebreak(is_ebreak), .o_reg_wen(reg_wen)
	);

	alu_branch u_alu_branch (
		.i_pc(pc), .i_rs1_data(rs1_data), .i_rs2_data(rs2_data), .i_imm(imm),
		.i_alu_op(alu_op), .i_src_a_pc(src_a_pc), .i_src_a_zero(src_a_zero),
		.i_src_b_imm(src_b_imm), .i_br_funct3(br_funct3),
		.o_alu_result(alu_result), .o_br_taken(br_taken)
	);

	lsu_align u_lsu_align (
		.i_addr(alu_result), .i_store_data(rs2_data), .i_mem_size(mem_size),
		.i_is_store(is_store), .i_load_unsigned(load_unsigned),
		.i_lsu_rdata(i_lsu_rdata), .o_lsu_addr(o_lsu_addr), .o_lsu_size(o_lsu_size),
		.o_lsu_wen(o_lsu_wen), .o_lsu_wdata(o_lsu_wdata), .o_lsu_wmask(o_lsu_wmask),
		.o_load_data(load_data)
	);

	reg_file u_reg_file (
		.clk(clk), .reset(reset), .i_rs1(rs1), .i_rs2(rs2), .i_rd(rd),
		.i_wen(rd_wen), .i_wdata(rd_wdata),
		.o_rs1_data(rs1_data), .o_rs2_data(rs2_data)
	);

endmodule

/* verif/tb_mem_model.sv */
`timescale 1ns/1ps

module tb_mem_model #(
	parameter logic [31:0] base = 32'h3000_0000,
	parameter int words = 2048
) (
	input  logic        clk,
	input  logic        reset,
	input  logic        i_ifu_req_valid,
	input  logic [31:0] i_ifu_addr,
	output logic        o_ifu_resp_valid,
	output logic [31:0] o_ifu_rdata,
	input  logic        i_lsu_req_valid,
	input  logic [31:0] i_lsu_addr,
	input  logic [1:0]  i_lsu_size,
	input  logic        i_lsu_wen,
	input  logic [31:0] i_lsu_wdata,
	input  logic [3:0]  i_lsu_wmask,
	output logic        o_lsu_resp_valid,
	output logic [31:0] o_lsu_rdata
);
	logic [31:0] mem [words];

	// one entry per data port request
	logic [31:0] log_addr [$];
	logic [1:0]  log_size [$];
	logic        log_wen [$];
	logic [3:0]  log_wmask [$];
	logic [31:0] log_wdata [$];

	logic        ifu_valid_q = 1'b0;
	logic [31:0] ifu_rdata_q = '0;
	logic        lsu_valid_q = 1'b0;
	logic [31:0] lsu_rdata_q = '0;
	logic        ifu_busy = 1'b0;
	logic        lsu_busy = 1'b0;
	logic [2:0]  ifu_delay = '0;
	logic [2:0]  lsu_delay = '0;
	logic [31:0] ifu_addr_q = '0;
	logic [31:0] lsu_addr_q = '0;

	assign o_ifu_resp_valid = ifu_valid_q;
	assign o_ifu_rdata = ifu_rdata_q;
	assign o_lsu_resp_valid = lsu_valid_q;
	assign o_lsu_rdata = lsu_rdata_q;

	function automatic int word_index(input logic [31:0] addr);
		logic [31:0] offset;
		offset = (addr - base) >> 2;
		return int'(offset) % words;
	endfunction

	task automatic fill_pattern();
		for (int i = 0; i < words; i++) begin
			mem[i] = (base + 32'(i * 4)) ^ 32'h5a5a_c3c3;  // differs per address
		end
	endtask

	always @(posedge clk) begin
		ifu_valid_q <= 1'b0;
		lsu_valid_q <= 1'b0;
		if (reset) begin
			ifu_busy <= 1'b0;
			lsu_busy <= 1'b0;
			log_addr.delete();
			log_size.delete();
			log_wen.delete();
			log_wmask.delete();
			log_wdata.delete();
		end else begin
			if (i_ifu_req_valid) begin
				ifu_busy <= 1'b1;
				ifu_addr_q <= i_ifu_addr;
				ifu_delay <= 3'($urandom_range(3, 0));
			end else if (ifu_busy) begin
				if (ifu_delay == 3'd0) begin
					ifu_valid_q <= 1'b1;
					ifu_rdata_q <= mem[word_index(ifu_addr_q)];
					ifu_busy <= 1'b0;
				end else begin
					ifu_delay <= ifu_delay - 3'd1;
				end
			end
			if (i_lsu_req_valid) begin
				log_addr.push_back(i_lsu_addr);
				log_size.push_back(i_lsu_size);
				log_wen.push_back(i_lsu_wen);
				log_wmask.push_back(i_lsu_wmask);
				log_wdata.push_back(i_lsu_wdata);
				for (int b = 0; b < 4; b++) begin
					if (i_lsu_wen && i_lsu_wmask[b]) begin
						mem[word_index(i_lsu_addr)][8*b +: 8] = i_lsu_wdata[8*b +: 8];
					end
				end
				lsu_busy <= 1'b1;
				lsu_addr_q <= i_lsu_addr;
				lsu_delay <= 3'($urandom_range(3, 0));
			end else if (lsu_busy) begin
				if (lsu_delay == 3'd0) begin
					lsu_valid_q <= 1'b1;
					lsu_rdata_q <= mem[word_index(lsu_addr_q)];
					lsu_busy <= 1'b0;
				end else begin
					lsu_delay <= lsu_delay - 3'd1;
				end
			end
		end
	end

endmodule

/* verif/tb_rv_core.sv */
`timescale 1ns/1ps

module tb_rv_core;
	import rv_pkg::*;

	localparam logic [31:0] reset_pc = 32'h3000_0000;
	localparam logic [31:0] data_base = reset_pc + 32'h1000;
	localparam int num_tests = 5;
	localparam int cycle_limit = num_tests * 2000;  // 60 instr at worst latency each

	logic        clk = 1'b0;
	logic        reset = 1'b1;
	logic        ifu_req_valid;
	logic [31:0] ifu_addr;
	logic        ifu_resp_valid;
	logic [31:0] ifu_rdata;
	logic        lsu_req_valid;
	logic [31:0] lsu_addr;
	logic [1:0]  lsu_size;
	logic        lsu_wen;
	logic [31:0] lsu_wdata;
	logic [3:0]  lsu_wmask;
	logic        lsu_resp_valid;
	logic [31:0] lsu_rdata;
	logic        halt;

	int          cycles = 0;
	logic [31:0] prog [$];
	logic [31:0] expect_q [$];
	logic [31:0] fetch_q [$];

	always #10 clk = ~clk;

	rv_core #(.reset_pc(reset_pc)) u_rv_core (
		.clk(clk), .reset(reset),
		.o_ifu_req_valid(ifu_req_valid), .o_ifu_addr(ifu_addr),
		.i_ifu_resp_valid(ifu_resp_valid), .i_ifu_rdata(ifu_rdata),
		.o_lsu_req_valid(lsu_req_valid), .o_lsu_addr(lsu_addr), .o_lsu_size(lsu_size),
		.o_lsu_wen(lsu_wen), .o_lsu_wdata(lsu_wdata), .o_lsu_wmask(lsu_wmask),
		.i_lsu_resp_valid(lsu_resp_valid), .i_lsu_rdata(lsu_rdata), .o_halt(halt)
	);

	tb_mem_model #(.base(reset_pc)) u_mem (
		.clk(clk), .reset(reset),
		.i_ifu_req_valid(ifu_req_valid), .i_ifu_addr(ifu_addr),
		.o_ifu_resp_valid(ifu_resp_valid), .o_ifu_rdata(ifu_rdata),
		.i_lsu_req_valid(lsu_req_valid), .i_lsu_addr(lsu_addr), .i_lsu_size(lsu_size),
		.i_lsu_wen(lsu_wen), .i_lsu_wdata(lsu_wdata), .i_lsu_wmask(lsu_wmask),
		.o_lsu_resp_valid(lsu_resp_valid), .o_lsu_rdata(lsu_rdata)
	);

	task automatic fail(input string what);
		$display("%s", what);
		$display("Done: errors found");
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("** Error %s: got %h, expected %h", name, got, exp);
			$display("Done: errors found");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			fail($sformatf("timeout: the core did not halt within %0d cycles", cycle_limit));
		end
		if (reset && (ifu_req_valid || lsu_req_valid)) begin
			fail("a bus request was issued while reset was high");
		end
		if (reset) begin
			fetch_q.delete();
		end else if (ifu_req_valid) begin
			fetch_q.push_back(ifu_addr);
		end
	end

	function automatic logic [31:0] r_type(input logic [6:0] f7, input int rs2, input int rs1,
		input logic [2:0] f3, input int rd);
		return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), op_op};
	endfunction

	function automatic logic [31:0] i_type(input logic [11:0] imm, input int rs1,
		input logic [2:0] f3, input int rd, input logic [6:0] op);
		return {imm, 5'(rs1), f3, 5'(rd), op};
	endfunction

	function automatic logic [31:0] s_type(input logic [11:0] imm, input int rs2, input int rs1,
		input logic [2:0] f3);
		return {imm[11:5], 5'(rs2), 5'(rs1), f3, imm[4:0], op_store};
	endfunction

	function automatic logic [31:0] b_type(input logic [12:0] imm, input int rs2, input int rs1,
		input logic [2:0] f3);
		return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), f3, imm[4:1], imm[11], op_branch};
	endfunction

	function automatic logic [31:0] u_type(input logic [19:0] imm, input int rd,
		input logic [6:0] op);
		return {imm, 5'(rd), op};
	endfunction

	function automatic logic [31:0] j_type(input logic [20:0] imm, input int rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), op_jal};
	endfunction

	function automatic logic [31:0] word_at(input logic [31:0] addr);
		return u_mem.mem[int'((addr - reset_pc) >> 2)];
	endfunction

	function automatic logic [31:0] lane_bits(input logic [3:0] m);
		return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
	endfunction

	task automatic emit(input logic [31:0] word);
		prog.push_back(word);
	endtask

	// op result goes to x4, then is stored at the next data slot
	task automatic op_and_store(input logic [31:0] inst, input logic [31:0] expected);
		emit(inst);
		emit(s_type(12'(4 * expect_q.size()), 4, 1, 3'b010));
		expect_q.push_back(expected);
	endtask

	task automatic start_program();
		@(posedge clk);
		reset <= 1'b1;
		u_mem.fill_pattern();
		foreach (prog[i]) begin
			u_mem.mem[i] = prog[i];
		end
		repeat (5) @(posedge clk);
		reset <= 1'b0;
	endtask

	task automatic wait_for_halt();
		while (halt !== 1'b1) begin
			@(posedge clk);
		end
	endtask

	task automatic alu_ops();
		prog.delete();
		expect_q.delete();
		emit(u_type(20'h30001, 1, op_lui));
		emit(u_type(20'h80001, 2, op_lui));
		emit(i_type(12'h234, 2, 3'b000, 2, op_op_imm));  // x2 = 8000_1234
		emit(u_type(20'hf0000, 3, op_lui));
		emit(i_type(12'h005, 3, 3'b000, 3, op_op_imm));  // x3 = f000_0005
		op_and_store(r_type(7'h00, 3, 2, 3'b000, 4), 32'h7000_1239);
		op_and_store(r_type(7'h20, 3, 2, 3'b000, 4), 32'h9000_122f);
		op_and_store(r_type(7'h00, 3, 2, 3'b010, 4), 32'd1);
		op_and_store(r_type(7'h00, 2, 3, 3'b010, 4), 32'd0);
		op_and_store(r_type(7'h00, 3, 2, 3'b011, 4), 32'd1);
		op_and_store(r_type(7'h00, 3, 2, 3'b111, 4), 32'h8000_0004);
		op_and_store(r_type(7'h00, 3, 2, 3'b110, 4), 32'hf000_1235);
		op_and_store(r_type(7'h00, 3, 2, 3'b100, 4), 32'h7000_1231);
		op_and_store(r_type(7'h00, 3, 2, 3'b001, 4), 32'h0002_4680);
		op_and_store(r_type(7'h00, 3, 2, 3'b101, 4), 32'h0400_0091);
		op_and_store(r_type(7'h20, 3, 2, 3'b101, 4), 32'hfc00_0091);
		op_and_store(i_type(12'hff9, 2, 3'b000, 4, op_op_imm), 32'h8000_122d);  // imm -7
		op_and_store(i_type(12'hff9, 2, 3'b010, 4, op_op_imm), 32'd1);
		op_and_store(i_type(12'hff9, 2, 3'b011, 4, op_op_imm), 32'd1);
		op_and_store(i_type(12'hff9, 2, 3'b111, 4, op_op_imm), 32'h8000_1230);
		op_and_store(i_type(12'hff9, 2, 3'b110, 4, op_op_imm), 32'hffff_fffd);
		op_and_store(i_type(12'hff9, 2, 3'b100, 4, op_op_imm), 32'h7fff_edcd);
		op_and_store(i_type(12'h003, 2, 3'b001, 4, op_op_imm), 32'h0000_91a0);
		op_and_store(i_type(12'h003, 2, 3'b101, 4, op_op_imm), 32'h1000_0246);
		op_and_store(i_type(12'h403, 2, 3'b101, 4, op_op_imm), 32'hf000_0246);
		emit(ebreak_word);
		start_program();
		wait_for_halt();
		foreach (expect_q[i]) begin
			check_value($sformatf("alu slot %0d", i), word_at(data_base + 32'(4 * i)), expect_q[i]);
		end
	endtask

	task automatic jumps_and_upper_imm();
		prog.delete();
		emit(u_type(20'h30001, 1, op_lui));
		emit(u_type(20'h12345, 5, op_lui));
		emit(s_type(12'h000, 5, 1, 3'b010));
		emit(u_type(20'h00010, 6, op_auipc));  // at offset 12
		emit(s_type(12'h004, 6, 1, 3'b010));
		emit(j_type(21'd12, 7));  // at 20, lands on 32
		emit(i_type(12'h001, 0, 3'b000, 8, op_op_imm));
		emit(s_type(12'h010, 8, 1, 3'b010));
		emit(s_type(12'h008, 7, 1, 3'b010));
		emit(u_type(20'h00000, 9, op_auipc));  // at 36
		emit(i_type(12'd17, 9, 3'b000, 10, op_jalr));  // odd target, bit 0 dropped
		emit(i_type(12'h001, 0, 3'b000, 8, op_op_imm));
		emit(s_type(12'h010, 8, 1, 3'b010));
		emit(s_type(12'h00c, 10, 1, 3'b010));  // at 52
		emit(s_type(12'h010, 8, 1, 3'b010));
		emit(ebreak_word);
		start_program();
		wait_for_halt();
		check_value("lui result", word_at(data_base), 32'h1234_5000);
		check_value("auipc result", word_at(data_base + 32'd4), reset_pc + 32'd12 + 32'h1_0000);
		check_value("jal link", word_at(data_base + 32'd8), reset_pc + 32'd20 + 32'd4);
		check_value("jalr link", word_at(data_base + 32'd12), reset_pc + 32'd40 + 32'd4);
		check_value("skipped marker", word_at(data_base + 32'd16), 32'd0);
		check_value("jal target", fetch_q[6], reset_pc + 32'd32);
		check_value("jalr target", fetch_q[9], reset_pc + 32'd52);
	endtask

	task automatic branch_paths();
		logic [2:0] f3s [12] = '{f3_beq, f3_beq, f3_bne, f3_bne, f3_blt, f3_blt,
			f3_bge, f3_bge, f3_bltu, f3_bltu, f3_bgeu, f3_bgeu};
		int lhs [12] = '{3, 2, 2, 3, 2, 3, 3, 2, 3, 2, 2, 3};
		int rhs [12] = '{3, 3, 3, 3, 3, 2, 2, 3, 2, 3, 3, 2};
		logic taken [12] = '{1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0,
			1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0};  // first of each pair branches
		logic [11:0] off;
		prog.delete();
		emit(u_type(20'h30001, 1, op_lui));
		emit(i_type(12'hfff, 0, 3'b000, 2, op_op_imm));  // x2 = -1
		emit(i_type(12'h001, 0, 3'b000, 3, op_op_imm));
		emit(i_type(12'h002, 0, 3'b000, 6, op_op_imm));
		for (int k = 0; k < 12; k++) begin
			off = 12'(4 * k);
			emit(b_type(13'd12, rhs[k], lhs[k], f3s[k]));
			emit(s_type(off, 3, 1, 3'b010));  // fall through writes 1
			emit(j_type(21'd8, 0));
			emit(s_type(off, 6, 1, 3'b010));  // taken path writes 2
		end
		emit(ebreak_word);
		start_program();
		wait_for_halt();
		for (int k = 0; k < 12; k++) begin
			check_value($sformatf("branch case %0d", k), word_at(data_base + 32'(4 * k)),
				taken[k] ? 32'd2 : 32'd1);
		end
	endtask

	task automatic subword_access();
		int offs [6] = '{0, 5, 10, 15, 16, 22};
		logic [1:0] sizes [14] = '{mem_byte, mem_byte, mem_byte, mem_byte, mem_half, mem_half,
			mem_byte, mem_byte, mem_half, mem_half, mem_word, mem_word, mem_word, mem_word};
		logic [31:0] v;
		logic [31:0] addr;
		logic [3:0]  mask;
		logic [31:0] lanes;
		logic [31:0] shifted;
		v = 32'h1234_87f6;
		prog.delete();
		emit(u_type(20'h30001, 1, op_lui));
		emit(u_type(20'h12348, 5, op_lui));
		emit(i_type(12'h7f6, 5, 3'b000, 5, op_op_imm));
		for (int k = 0; k < 6; k++) begin
			emit(s_type(12'(offs[k]), 5, 1, (k < 4) ? 3'b000 : 3'b001));
		end
		emit(i_type(12'h00f, 1, 3'b000, 6, op_load));
		emit(i_type(12'h00f, 1, 3'b100, 7, op_load));
		emit(i_type(12'h016, 1, 3'b001, 8, op_load));
		emit(i_type(12'h016, 1, 3'b101, 9, op_load));
		for (int r = 6; r < 10; r++) begin
			emit(s_type(12'(32 + 4 * (r - 6)), r, 1, 3'b010));
		end
		emit(ebreak_word);
		start_program();
		wait_for_halt();
		check_value("data request count", 32'(u_mem.log_addr.size()), 32'd14);
		for (int k = 0; k < 14; k++) begin
			check_value("o_lsu_size", 32'(u_mem.log_size[k]), 32'(sizes[k]));
		end
		for (int k = 0; k < 6; k++) begin
			addr = data_base + 32'(offs[k]);
			mask = (k < 4) ? (4'b0001 << addr[1:0]) : (4'b0011 << addr[1:0]);
			lanes = lane_bits(mask);
			shifted = v << (8 * addr[1:0]);
			check_value("o_lsu_addr", u_mem.log_addr[k], addr);
			check_value("o_lsu_wen", 32'(u_mem.log_wen[k]), 32'd1);
			check_value("o_lsu_wmask", 32'(u_mem.log_wmask[k]), 32'(mask));
			check_value("o_lsu_wdata", u_mem.log_wdata[k] & lanes, shifted & lanes);
			check_value($sformatf("stored word %0d", k), word_at(addr),
				((addr & ~32'd3) ^ 32'h5a5a_c3c3) & ~lanes | (shifted & lanes));
		end
		for (int k = 6; k < 10; k++) begin
			check_value("o_lsu_wen", 32'(u_mem.log_wen[k]), 32'd0);
			check_value("o_lsu_wmask", 32'(u_mem.log_wmask[k]), 32'd0);
		end
		check_value("lb result", word_at(data_base + 32'h20), {{24{v[7]}}, v[7:0]});
		check_value("lbu result", word_at(data_base + 32'h24), {24'd0, v[7:0]});
		check_value("lh result", word_at(data_base + 32'h28), {{16{v[15]}}, v[15:0]});
		check_value("lhu result", word_at(data_base + 32'h2c), {16'd0, v[15:0]});
	endtask

	task automatic reset_and_halt();
		prog.delete();
		emit(i_type(12'h003, 0, 3'b000, 2, op_op_imm));
		emit(b_type(13'd8, 0, 0, f3_beq));  // at 4, to 12
		emit(i_type(12'h009, 0, 3'b000, 2, op_op_imm));
		emit(j_type(21'd8, 0));  // at 12, to 20
		emit(i_type(12'h000, 0, 3'b000, 0, op_op_imm));
		emit(ebreak_word);
		start_program();
		@(posedge clk);
		check_value("o_ifu_req_valid", 32'(ifu_req_valid), 32'd1);
		check_value("o_ifu_addr", ifu_addr, reset_pc);
		wait_for_halt();
		check_value("fetch count", 32'(fetch_q.size()), 32'd4);
		check_value("fetch 0", fetch_q[0], reset_pc);
		check_value("fetch 1", fetch_q[1], reset_pc + 32'd4);
		check_value("fetch 2", fetch_q[2], reset_pc + 32'd4 + 32'd8);
		check_value("fetch 3", fetch_q[3], reset_pc + 32'd12 + 32'd8);
		repeat (50) begin
			@(posedge clk);
			check_value("o_halt", 32'(halt), 32'd1);
			if (ifu_req_valid || lsu_req_valid) begin
				fail("a bus request was issued after the core halted");
			end
		end
	endtask

	initial begin
		void'($urandom(32'h4689_7cec));
		alu_ops();
		jumps_and_upper_imm();
		branch_paths();
		subword_access();
		reset_and_halt();
		$display("Done: no errors");
		$finish;
	end

endmodule

/* sources.f */
design/rv_pkg.sv
design/reg_file.sv
design/inst_decode.sv
design/alu_branch.sv
design/lsu_align.sv
design/core_ctrl.sv
design/rv_core.sv
verif/tb_mem_model.sv
verif/tb_rv_core.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_rv_core
FILELIST  = sources.f

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

.PHONY: sim clean
